// File: hdl/rubik_pkg.sv
package rubik_pkg;

  // ==========================================================
  // widths and counts
  // ==========================================================
  localparam int ADDR_W      = 32; // byte address
  localparam int DATA_W      = 64; // memory word
  localparam int REG_OFS_W   = 4;  // register word offset
  localparam int REG_DATA_W  = 32;
  localparam int TILE_CNT_W  = 5;  // 1..16 tiles
  localparam int ELEMS_INT8  = 8;  // also K for int8
  localparam int ELEMS_INT16 = 4;  // also K for int16
  localparam int LINE_IDX_W  = 3;  // line index inside a tile
  localparam int OP_LINE_W   = TILE_CNT_W + LINE_IDX_W; // lines per operation

  // ==========================================================
  // register map
  // ==========================================================
  localparam logic [REG_OFS_W-1:0] REG_OP_EN        = 4'd0;
  localparam logic [REG_OFS_W-1:0] REG_PRECISION    = 4'd1;
  localparam logic [REG_OFS_W-1:0] REG_DAIN_ADDR    = 4'd2;
  localparam logic [REG_OFS_W-1:0] REG_DAOUT_ADDR   = 4'd3;
  localparam logic [REG_OFS_W-1:0] REG_DAIN_STRIDE  = 4'd4;
  localparam logic [REG_OFS_W-1:0] REG_DAOUT_STRIDE = 4'd5;
  localparam logic [REG_OFS_W-1:0] REG_TILES        = 4'd6;
  localparam logic [REG_OFS_W-1:0] REG_STATUS       = 4'd7; // sticky done, w1c

  typedef struct packed {
    logic                  wr;    // 1 write, 0 read
    logic [REG_OFS_W-1:0]  ofs;
    logic [REG_DATA_W-1:0] wdata;
  } csb_req_t;

  typedef struct packed {
    logic                  precision; // 0 int8, 1 int16
    logic [ADDR_W-1:0]     dain_addr;
    logic [ADDR_W-1:0]     daout_addr;
    logic [ADDR_W-1:0]     dain_stride;
    logic [ADDR_W-1:0]     daout_stride;
    logic [TILE_CNT_W-1:0] tiles;
  } rubik_cfg_t;

  // element 0 sits in the low bits for both views
  typedef union packed {
    logic [ELEMS_INT8-1:0][7:0]   b;
    logic [ELEMS_INT16-1:0][15:0] h;
  } rubik_word_u;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } dma_rd_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    rubik_word_u       data;
  } dma_wr_req_t;

  // lines per tile for the given precision
  function automatic logic [LINE_IDX_W:0] tile_k(input logic precision);
    return precision ? (LINE_IDX_W+1)'(ELEMS_INT16) : (LINE_IDX_W+1)'(ELEMS_INT8);
  endfunction

  function automatic logic [OP_LINE_W-1:0] op_lines(input rubik_cfg_t cfg);
    return OP_LINE_W'(cfg.tiles) * OP_LINE_W'(tile_k(cfg.precision));
  endfunction

endpackage

// File: hdl/rubik_regfile.sv
module rubik_regfile (
   input  logic                             nvdla_core_clk
  ,input  logic                             rst
  ,input  logic                             csb_req_valid
  ,input  rubik_pkg::csb_req_t              csb_req
  ,input  logic                             op_done
  ,output logic                             csb_resp_valid
  ,output logic [rubik_pkg::REG_DATA_W-1:0] csb_resp_data
  ,output logic                             op_start
  ,output rubik_pkg::rubik_cfg_t            cfg
  ,output logic                             done_intr
);
  import rubik_pkg::*;

  logic                  op_en;
  logic                  status_done;
  logic                  wr_en;
  logic                  cfg_wr_en;
  logic                  start_req;
  logic                  rd_en;
  logic [REG_DATA_W-1:0] rd_data;

  assign wr_en     = csb_req_valid && csb_req.wr;
  assign rd_en     = csb_req_valid && !csb_req.wr;
  assign cfg_wr_en = wr_en && !op_en;                   // config frozen while busy
  assign start_req = cfg_wr_en && (csb_req.ofs == REG_OP_EN) && csb_req.wdata[0];

  // ==========================================================
  // control and configuration registers
  // ==========================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      op_en       <= 1'b0;
      op_start    <= 1'b0;
      status_done <= 1'b0;
      done_intr   <= 1'b0;
      cfg         <= '0;
    end else begin
      op_start  <= start_req;
      done_intr <= op_done;
      if (op_done) begin
        op_en <= 1'b0;
      end else if (start_req) begin
        op_en <= 1'b1;
      end
      if (op_done) begin
        status_done <= 1'b1;                            // set beats clear
      end else if (wr_en && (csb_req.ofs == REG_STATUS) && csb_req.wdata[0]) begin
        status_done <= 1'b0;
      end
      if (cfg_wr_en) begin
        case (csb_req.ofs)
          REG_PRECISION:    cfg.precision    <= csb_req.wdata[0];
          REG_DAIN_ADDR:    cfg.dain_addr    <= csb_req.wdata;
          REG_DAOUT_ADDR:   cfg.daout_addr   <= csb_req.wdata;
          REG_DAIN_STRIDE:  cfg.dain_stride  <= csb_req.wdata;
          REG_DAOUT_STRIDE: cfg.daout_stride <= csb_req.wdata;
          REG_TILES:        cfg.tiles        <= csb_req.wdata[TILE_CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // readback mux, offsets 8 and up read zero
  always_comb begin
    rd_data = '0;
    case (csb_req.ofs)
      REG_OP_EN:        rd_data[0] = op_en;
      REG_PRECISION:    rd_data[0] = cfg.precision;
      REG_DAIN_ADDR:    rd_data = cfg.dain_addr;
      REG_DAOUT_ADDR:   rd_data = cfg.daout_addr;
      REG_DAIN_STRIDE:  rd_data = cfg.dain_stride;
      REG_DAOUT_STRIDE: rd_data = cfg.daout_stride;
      REG_TILES:        rd_data[TILE_CNT_W-1:0] = cfg.tiles;
      REG_STATUS:       rd_data[0] = status_done;
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= rd_en;                          // reads only, one cycle later
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      csb_resp_data <= rd_data;
    end
  end

endmodule

// File: hdl/rubik_seq_gen.sv
module rubik_seq_gen (
   input  logic                   nvdla_core_clk
  ,input  logic                   rst
  ,input  logic                   op_start
  ,input  rubik_pkg::rubik_cfg_t  cfg
  ,input  logic                   rd_req_ready
  ,output logic                   rd_req_valid
  ,output rubik_pkg::dma_rd_req_t rd_req
);
  import rubik_pkg::*;

  logic [OP_LINE_W-1:0] total_lines;
  logic [OP_LINE_W-1:0] line_cnt;
  logic                 rd_accept;
  logic                 last_line;

  // ==========================================================
  // request count for the whole operation
  // ==========================================================
  assign total_lines = op_lines(cfg);                  // tiles times 8 or 4
  assign rd_accept   = rd_req_valid && rd_req_ready;
  assign last_line   = (line_cnt == total_lines - 1'b1);

  // tiles go out back to back, the response port does the stalling
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      rd_req_valid <= 1'b0;
      line_cnt     <= '0;
    end else if (op_start) begin
      rd_req_valid <= 1'b1;
      line_cnt     <= '0;
    end else if (rd_accept) begin
      if (last_line) begin
        rd_req_valid <= 1'b0;                          // all lines requested
      end
      line_cnt <= line_cnt + 1'b1;
    end
  end

  // ==========================================================
  // address accumulator
  // ==========================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (op_start) begin
      rd_req.addr <= cfg.dain_addr;
    end else if (rd_accept) begin
      rd_req.addr <= rd_req.addr + cfg.dain_stride;    // next input line
    end
  end

endmodule

// File: hdl/rubik_tile_buf.sv
module rubik_tile_buf (
   input  logic                   nvdla_core_clk
  ,input  logic                   rst
  ,input  logic                   op_start
  ,input  rubik_pkg::rubik_cfg_t  cfg
  ,input  logic                   rd_rsp_valid
  ,input  rubik_pkg::rubik_word_u rd_rsp_data
  ,input  logic                   col_ready
  ,output logic                   rd_rsp_ready
  ,output logic                   col_valid
  ,output rubik_pkg::rubik_word_u col_data
  ,output logic                   col_last
);
  import rubik_pkg::*;

  rubik_word_u           tile_mem [ELEMS_INT8];
  logic [LINE_IDX_W-1:0] wr_idx;
  logic [LINE_IDX_W-1:0] col_idx;
  logic [TILE_CNT_W-1:0] tile_cnt;
  logic [LINE_IDX_W-1:0] k_last;
  logic                  rsp_accept;
  logic                  col_accept;
  logic                  last_tile;

  assign k_last     = LINE_IDX_W'(tile_k(cfg.precision) - 1'b1);
  assign rsp_accept = rd_rsp_valid && rd_rsp_ready;
  assign col_accept = col_valid && col_ready;
  assign last_tile  = (tile_cnt == cfg.tiles - 1'b1);
  assign col_last   = last_tile && (col_idx == k_last);

  // ==========================================================
  // fill / drain control
  // ==========================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (rst || op_start) begin
      rd_rsp_ready <= op_start && !rst;                // fill the first tile
      col_valid    <= 1'b0;
      wr_idx       <= '0;
      col_idx      <= '0;
      tile_cnt     <= '0;
    end else begin
      if (rsp_accept) begin
        if (wr_idx == k_last) begin
          rd_rsp_ready <= 1'b0;                        // tile complete
          col_valid    <= 1'b1;
          wr_idx       <= '0;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
      if (col_accept) begin
        if (col_idx == k_last) begin
          col_valid <= 1'b0;
          col_idx   <= '0;
          if (!last_tile) begin
            rd_rsp_ready <= 1'b1;                      // refill for next tile
            tile_cnt     <= tile_cnt + 1'b1;
          end
        end else begin
          col_idx <= col_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rsp_accept) begin
      tile_mem[wr_idx] <= rd_rsp_data;
    end
  end

  // column j gathers element j of every stored line
  always_comb begin
    col_data = '0;
    if (cfg.precision) begin
      for (int i = 0; i < ELEMS_INT16; i++) begin
        col_data.h[i] = tile_mem[i].h[col_idx[1:0]];
      end
    end else begin
      for (int i = 0; i < ELEMS_INT8; i++) begin
        col_data.b[i] = tile_mem[i].b[col_idx];
      end
    end
  end

endmodule

// File: hdl/rubik_wr_req.sv
module rubik_wr_req (
   input  logic                   nvdla_core_clk
  ,input  logic                   rst
  ,input  logic                   op_start
  ,input  rubik_pkg::rubik_cfg_t  cfg
  ,input  logic                   col_valid
  ,input  rubik_pkg::rubik_word_u col_data
  ,input  logic                   col_last
  ,input  logic                   wr_req_ready
  ,input  logic                   wr_rsp_complete
  ,output logic                   col_ready
  ,output logic                   wr_req_valid
  ,output rubik_pkg::dma_wr_req_t wr_req
  ,output logic                   op_done
);
  import rubik_pkg::*;

  logic [ADDR_W-1:0]    out_addr;
  logic                 last_q;        // register holds the final column
  logic                 last_issued;
  logic [OP_LINE_W-1:0] issued_cnt;
  logic [OP_LINE_W-1:0] cmpl_cnt;
  logic                 col_accept;
  logic                 wr_accept;

  assign col_ready  = !wr_req_valid || wr_req_ready;   // empty or draining
  assign col_accept = col_valid && col_ready;
  assign wr_accept  = wr_req_valid && wr_req_ready;
  assign op_done    = wr_rsp_complete && last_issued && (cmpl_cnt + 1'b1 == issued_cnt);

  // ==========================================================
  // output register and completion tracking
  // ==========================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (rst || op_start) begin
      wr_req_valid <= 1'b0;
      last_q       <= 1'b0;
      last_issued  <= 1'b0;
      issued_cnt   <= '0;
      cmpl_cnt     <= '0;
    end else begin
      if (col_accept) begin
        wr_req_valid <= 1'b1;
        last_q       <= col_last;
      end else if (wr_accept) begin
        wr_req_valid <= 1'b0;
      end
      if (wr_accept) begin
        issued_cnt <= issued_cnt + 1'b1;
        if (last_q) begin
          last_issued <= 1'b1;
        end
      end
      if (wr_rsp_complete) begin
        cmpl_cnt <= cmpl_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (op_start) begin
      out_addr <= cfg.daout_addr;
    end else if (col_accept) begin
      wr_req.addr <= out_addr;
      wr_req.data <= col_data;
      out_addr    <= out_addr + cfg.daout_stride;      // next output line
    end
  end

endmodule

// File: hdl/rubik_top.sv
module rubik_top (
   input  logic                             nvdla_core_clk
  ,input  logic                             rst
  ,input  logic                             csb_req_valid
  ,input  rubik_pkg::csb_req_t              csb_req
  ,output logic                             csb_resp_valid
  ,output logic [rubik_pkg::REG_DATA_W-1:0] csb_resp_data
  ,output logic                             rd_req_valid
  ,input  logic                             rd_req_ready
  ,output rubik_pkg::dma_rd_req_t           rd_req
  ,input  logic                             rd_rsp_valid
  ,output logic                             rd_rsp_ready
  ,input  rubik_pkg::rubik_word_u           rd_rsp_data
  ,output logic                             wr_req_valid
  ,input  logic                             wr_req_ready
  ,output rubik_pkg::dma_wr_req_t           wr_req
  ,input  logic                             wr_rsp_complete
  ,output logic                             done_intr
);
  import rubik_pkg::*;

  rubik_cfg_t  cfg;
  rubik_word_u col_data;
  logic        op_start;
  logic        op_done;
  logic        col_valid;
  logic        col_ready;
  logic        col_last;

  // ==========================================================
  // decode
  // ==========================================================
  rubik_regfile u_regfile (
     .nvdla_core_clk  (nvdla_core_clk)
    ,.rst             (rst)
    ,.csb_req_valid   (csb_req_valid)
    ,.csb_req         (csb_req)
    ,.op_done         (op_done)
    ,.csb_resp_valid  (csb_resp_valid)
    ,.csb_resp_data   (csb_resp_data)
    ,.op_start        (op_start)
    ,.cfg             (cfg)
    ,.done_intr       (done_intr)
  );

  rubik_seq_gen u_seq_gen (
     .nvdla_core_clk  (nvdla_core_clk)
    ,.rst             (rst)
    ,.op_start        (op_start)
    ,.cfg             (cfg)
    ,.rd_req_ready    (rd_req_ready)
    ,.rd_req_valid    (rd_req_valid)
    ,.rd_req          (rd_req)
  );

  rubik_tile_buf u_tile_buf (
     .nvdla_core_clk  (nvdla_core_clk)
    ,.rst             (rst)
    ,.op_start        (op_start)
    ,.cfg             (cfg)
    ,.rd_rsp_valid    (rd_rsp_valid)
    ,.rd_rsp_data     (rd_rsp_data)
    ,.col_ready       (col_ready)
    ,.rd_rsp_ready    (rd_rsp_ready)
    ,.col_valid       (col_valid)
    ,.col_data        (col_data)
    ,.col_last        (col_last)
  );

  rubik_wr_req u_wr_req (
     .nvdla_core_clk  (nvdla_core_clk)
    ,.rst             (rst)
    ,.op_start        (op_start)
    ,.cfg             (cfg)
    ,.col_valid       (col_valid)
    ,.col_data        (col_data)
    ,.col_last        (col_last)
    ,.wr_req_ready    (wr_req_ready)
    ,.wr_rsp_complete (wr_rsp_complete)
    ,.col_ready       (col_ready)
    ,.wr_req_valid    (wr_req_valid)
    ,.wr_req          (wr_req)
    ,.op_done         (op_done)
  );

endmodule

// File: tb/rubik_checker.sv
module rubik_checker (
   input logic                   nvdla_core_clk
  ,input logic                   rst
  ,input logic                   csb_req_valid
  ,input rubik_pkg::csb_req_t    csb_req
  ,input logic                   csb_resp_valid
  ,input logic                   rd_req_valid
  ,input logic                   rd_req_ready
  ,input rubik_pkg::dma_rd_req_t rd_req
  ,input logic                   rd_rsp_valid
  ,input logic                   rd_rsp_ready
  ,input rubik_pkg::rubik_word_u rd_rsp_data
  ,input logic                   col_valid
  ,input logic                   col_ready
  ,input rubik_pkg::rubik_word_u col_data
  ,input logic                   wr_req_valid
  ,input logic                   wr_req_ready
  ,input rubik_pkg::dma_wr_req_t wr_req
  ,input logic                   done_intr
);

  int fail_cnt = 0;

  // ==========================================================
  // valid holds with a stable payload until ready
  // ==========================================================
  rd_req_hold: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
    else begin
      fail_cnt++;
      $error("rd_req dropped or changed while stalled");
    end

  rd_rsp_hold: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp_data))
    else begin
      fail_cnt++;
      $error("read response dropped or changed while stalled");
    end

  col_hold: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    col_valid && !col_ready |=> col_valid && $stable(col_data))
    else begin
      fail_cnt++;
      $error("column dropped or changed while stalled");
    end

  wr_req_hold: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req))
    else begin
      fail_cnt++;
      $error("wr_req dropped or changed while stalled");
    end

  done_pulse: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    done_intr |=> !done_intr)
    else begin
      fail_cnt++;
      $error("done_intr longer than one cycle");
    end

  // register reads answered exactly one cycle later
  csb_resp_after_rd: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    csb_req_valid && !csb_req.wr |=> csb_resp_valid)
    else begin
      fail_cnt++;
      $error("register read not answered in the next cycle");
    end

  csb_resp_only_rd: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    csb_resp_valid |-> $past(csb_req_valid && !csb_req.wr))
    else begin
      fail_cnt++;
      $error("register response without a read one cycle earlier");
    end

endmodule

bind rubik_top rubik_checker u_checker (
   .nvdla_core_clk  (nvdla_core_clk)
  ,.rst             (rst)
  ,.csb_req_valid   (csb_req_valid)
  ,.csb_req         (csb_req)
  ,.csb_resp_valid  (csb_resp_valid)
  ,.rd_req_valid    (rd_req_valid)
  ,.rd_req_ready    (rd_req_ready)
  ,.rd_req          (rd_req)
  ,.rd_rsp_valid    (rd_rsp_valid)
  ,.rd_rsp_ready    (rd_rsp_ready)
  ,.rd_rsp_data     (rd_rsp_data)
  ,.col_valid       (col_valid)
  ,.col_ready       (col_ready)
  ,.col_data        (col_data)
  ,.wr_req_valid    (wr_req_valid)
  ,.wr_req_ready    (wr_req_ready)
  ,.wr_req          (wr_req)
  ,.done_intr       (done_intr)
);

// File: tb/rubik_tb.sv
module rubik_tb;
  import rubik_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int DRIVE_DLY       = 1;
  localparam int RST_CYCLES      = 16;
  localparam int TOTAL_LINES     = 2 * 8 + 3 * 4 + 5 * 8; // lines over all three operations
  localparam int WATCHDOG_CYCLES = TOTAL_LINES * 60 + 1400;

  logic        nvdla_core_clk;
  logic        rst;
  logic        csb_req_valid;
  csb_req_t    csb_req;
  logic        csb_resp_valid;
  logic [31:0] csb_resp_data;
  logic        rd_req_valid;
  logic        rd_req_ready;
  dma_rd_req_t rd_req;
  logic        rd_rsp_valid;
  logic        rd_rsp_ready;
  rubik_word_u rd_rsp_data;
  logic        wr_req_valid;
  logic        wr_req_ready;
  dma_wr_req_t wr_req;
  logic        wr_rsp_complete;
  logic        done_intr;

  // expected operation, written by the main sequence only
  logic        exp_prec;
  logic [31:0] exp_dain;
  logic [31:0] exp_daout;
  logic [31:0] exp_istride;
  logic [31:0] exp_ostride;
  int          exp_lines = 0;
  int          rd_base   = 0;
  int          wr_base   = 0;
  int          cmpl_base = 0;
  int          done_base = 0;

  // memory model state
  logic [31:0] lfsr       = 32'h5f1e9d71;
  logic [31:0] rd_q[$];
  int          cmpl_due[$];
  int          cycle      = 0;
  int          rd_cnt     = 0;
  int          wr_cnt     = 0;
  int          cmpl_cnt   = 0;
  int          done_cnt   = 0;
  int          mem_errors = 0;
  int          reg_errors = 0;

  rubik_top i_rubik_top (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(CLK_PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  // ==========================================================
  // reference model
  // ==========================================================
  function automatic logic next_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // galois step
    return lfsr[0];
  endfunction

  function automatic logic [63:0] mem_word(input logic [31:0] addr);
    return {addr ^ 32'h3c6e_f372, addr * 32'h9e37_79b1 + 32'h7f4a_7c15};
  endfunction

  function automatic logic [31:0] in_addr(input int n);
    return exp_dain + 32'(n) * exp_istride;
  endfunction

  function automatic logic [31:0] out_addr(input int m);
    return exp_daout + 32'(m) * exp_ostride;
  endfunction

  // element i of output line m is element (m mod k) of input line (m div k)*k + i
  function automatic logic [63:0] exp_word(input int m);
    logic [63:0] src;
    logic [63:0] w;
    int          k;
    int          j;
    int          first;
    k     = exp_prec ? ELEMS_INT16 : ELEMS_INT8;
    j     = m % k;
    first = (m / k) * k;
    w     = '0;
    for (int i = 0; i < k; i++) begin
      src = mem_word(in_addr(first + i));
      if (exp_prec) begin
        w[16*i +: 16] = src[16*j +: 16];
      end else begin
        w[8*i +: 8] = src[8*j +: 8];
      end
    end
    return w;
  endfunction

  function automatic void show_mismatch(input string name, input logic [63:0] got,
                                        input logic [63:0] exp);
    $display("error %s: got %h, expected %h", name, got, exp);
  endfunction

  // ==========================================================
  // memory model with random back-pressure
  // ==========================================================
  initial begin : mem_model
    logic        rsp_hold;
    logic [63:0] got_data;
    int          dly;
    int          m;
    rd_req_ready    = 1'b0;
    rd_rsp_valid    = 1'b0;
    rd_rsp_data     = '0;
    wr_req_ready    = 1'b0;
    wr_rsp_complete = 1'b0;
    forever begin
      @(posedge nvdla_core_clk);
      cycle++;
      rsp_hold = rd_rsp_valid && !rd_rsp_ready;        // response must stay put
      if (!rst) begin
        if (rd_req_valid && rd_req_ready) begin
          assert (rd_req.addr == in_addr(rd_cnt - rd_base)) else begin
            mem_errors++;
            show_mismatch("rd_req.addr", 64'(rd_req.addr), 64'(in_addr(rd_cnt - rd_base)));
          end
          rd_q.push_back(rd_req.addr);
          rd_cnt++;
        end
        if (rd_rsp_valid && rd_rsp_ready) begin
          void'(rd_q.pop_front());
        end
        if (wr_req_valid && wr_req_ready) begin
          m        = wr_cnt - wr_base;
          got_data = wr_req.data;
          assert (m < exp_lines) else begin
            mem_errors++;
            $display("write %0d accepted beyond the expected %0d writes", m, exp_lines);
          end
          assert (wr_req.addr == out_addr(m)) else begin
            mem_errors++;
            show_mismatch("wr_req.addr", 64'(wr_req.addr), 64'(out_addr(m)));
          end
          assert (got_data == exp_word(m)) else begin
            mem_errors++;
            show_mismatch("wr_req.data", got_data, exp_word(m));
          end
          wr_cnt++;
          dly = 2;
          if (next_bit()) dly += 1;
          if (next_bit()) dly += 2;
          cmpl_due.push_back(cycle + dly);
        end
        if (wr_rsp_complete) begin
          cmpl_cnt++;
        end
        if (done_intr) begin
          assert (cmpl_cnt - cmpl_base == exp_lines) else begin
            mem_errors++;
            $display("done_intr raised before all %0d writes completed", exp_lines);
          end
          done_cnt++;
        end
      end
      #DRIVE_DLY;
      rd_req_ready = next_bit();
      wr_req_ready = next_bit();
      if (!rsp_hold) begin
        if (rd_q.size() > 0 && next_bit()) begin
          rd_rsp_valid = 1'b1;
          rd_rsp_data  = mem_word(rd_q[0]);              // in request order
        end else begin
          rd_rsp_valid = 1'b0;
        end
      end
      if (cmpl_due.size() > 0 && cmpl_due[0] <= cycle) begin
        wr_rsp_complete = 1'b1;
        void'(cmpl_due.pop_front());
      end else begin
        wr_rsp_complete = 1'b0;
      end
    end
  end

  // ==========================================================
  // register access
  // ==========================================================
  task automatic reg_write(input logic [3:0] ofs, input logic [31:0] data);
    csb_req_valid = 1'b1;
    csb_req.wr    = 1'b1;
    csb_req.ofs   = ofs;
    csb_req.wdata = data;
    @(posedge nvdla_core_clk);
    #DRIVE_DLY;
    csb_req_valid = 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] ofs, output logic [31:0] data);
    csb_req_valid = 1'b1;
    csb_req.wr    = 1'b0;
    csb_req.ofs   = ofs;
    csb_req.wdata = '0;
    @(posedge nvdla_core_clk);
    #DRIVE_DLY;
    csb_req_valid = 1'b0;
    assert (csb_resp_valid) else begin
      reg_errors++;
      $display("no register response one cycle after the read of offset %0d", ofs);
    end
    data = csb_resp_data;
  endtask

  task automatic check_reg(input string name, input logic [3:0] ofs, input logic [31:0] exp);
    logic [31:0] got;
    reg_read(ofs, got);
    assert (got == exp) else begin
      reg_errors++;
      show_mismatch(name, 64'(got), 64'(exp));
    end
  endtask

  task automatic write_readback(input string name, input logic [3:0] ofs,
                                input logic [31:0] data);
    reg_write(ofs, data);
    check_reg(name, ofs, data);
  endtask

  // ==========================================================
  // one operation, start to done
  // ==========================================================
  task automatic run_op(input logic prec, input logic [31:0] dain, input logic [31:0] daout,
                        input logic [31:0] istride, input logic [31:0] ostride,
                        input int tiles);
    int limit;
    int n;
    exp_prec    = prec;
    exp_dain    = dain;
    exp_daout   = daout;
    exp_istride = istride;
    exp_ostride = ostride;
    exp_lines   = tiles * (prec ? ELEMS_INT16 : ELEMS_INT8);
    rd_base     = rd_cnt;
    wr_base     = wr_cnt;
    cmpl_base   = cmpl_cnt;
    done_base   = done_cnt;
    limit       = exp_lines * 60 + 200;
    reg_write(REG_PRECISION, {31'd0, prec});
    reg_write(REG_DAIN_ADDR, dain);
    reg_write(REG_DAOUT_ADDR, daout);
    reg_write(REG_DAIN_STRIDE, istride);
    reg_write(REG_DAOUT_STRIDE, ostride);
    reg_write(REG_TILES, 32'(tiles));
    reg_write(REG_OP_EN, 32'd1);
    n = 0;
    while (!done_intr && n < limit) begin
      @(posedge nvdla_core_clk);
      n++;
    end
    #DRIVE_DLY;
    assert (n < limit) else begin
      reg_errors++;
      $display("done_intr did not arrive within %0d cycles", limit);
    end
    check_reg("op_en", REG_OP_EN, 32'd0);
    check_reg("status", REG_STATUS, 32'd1);
    reg_write(REG_STATUS, 32'd1);                        // w1c
    check_reg("status", REG_STATUS, 32'd0);
    repeat (20) @(posedge nvdla_core_clk);               // catch late or repeated writes
    #DRIVE_DLY;
    assert (rd_cnt - rd_base == exp_lines && wr_cnt - wr_base == exp_lines) else begin
      reg_errors++;
      $display("saw %0d reads and %0d writes, expected %0d of each",
               rd_cnt - rd_base, wr_cnt - wr_base, exp_lines);
    end
    assert (done_cnt - done_base == 1) else begin
      reg_errors++;
      $display("done_intr pulsed %0d times in one operation", done_cnt - done_base);
    end
  endtask

  // ==========================================================
  // main sequence
  // ==========================================================
  initial begin
    rst           = 1'b1;
    csb_req_valid = 1'b0;
    csb_req       = '0;
    repeat (RST_CYCLES) @(posedge nvdla_core_clk);
    #DRIVE_DLY;
    rst = 1'b0;
    assert (!rd_req_valid && !rd_rsp_ready && !wr_req_valid && !csb_resp_valid && !done_intr)
      else begin
      reg_errors++;
      $display("DUT outputs not idle after reset");
    end
    check_reg("op_en", REG_OP_EN, 32'd0);
    write_readback("precision", REG_PRECISION, 32'd1);
    write_readback("dain_addr", REG_DAIN_ADDR, 32'h8765_4320);
    write_readback("daout_addr", REG_DAOUT_ADDR, 32'h1357_9bd8);
    write_readback("dain_stride", REG_DAIN_STRIDE, 32'h0000_0140);
    write_readback("daout_stride", REG_DAOUT_STRIDE, 32'h0000_0088);
    write_readback("tiles", REG_TILES, 32'd9);
    check_reg("status", REG_STATUS, 32'd0);
    for (int ofs = 8; ofs < 16; ofs++) begin
      check_reg("unused offset", 4'(ofs), 32'd0);        // reads zero
    end

    run_op(1'b0, 32'h0001_0000, 32'h0008_0000, 32'h0000_0040, 32'h0000_0028, 2);
    run_op(1'b1, 32'h0003_0010, 32'h000a_0400, 32'h0000_0018, 32'h0000_0100, 3);
    run_op(1'b0, 32'h1234_5600, 32'h4000_0000, 32'h0000_0008, 32'h0000_0030, 5);

    $display("errors: register %0d, memory %0d, protocol %0d",
             reg_errors, mem_errors, i_rubik_top.u_checker.fail_cnt);
    if (reg_errors == 0 && mem_errors == 0 && i_rubik_top.u_checker.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog sized from the line count of all operations
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: vlog.f
hdl/rubik_pkg.sv
hdl/rubik_regfile.sv
hdl/rubik_seq_gen.sv
hdl/rubik_tile_buf.sv
hdl/rubik_wr_req.sv
hdl/rubik_top.sv
tb/rubik_checker.sv
tb/rubik_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rubik testbench with Verilator, run from the project root
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module rubik_tb -o rubik_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# a high error limit lets the testbench reach its closing summary
./obj_dir/rubik_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
exit 1
